// File: acb_assert.sv
/*
 * ADC strobe assertions, bound into the SAR sequencer
 */
`timescale 1ns/1ps

module acb_assert import acb_pkg::*; (
   input logic                clk40,
   input logic                arst_n,
   input logic                adc_soc,
   input logic                sample,
   input logic                adc_eoc_b,
   input logic [ADC_BITS-1:0] adc_out
);

   // End strobe is a single cycle
   a_eoc_one_cycle: assert property (
      @(posedge clk40) disable iff (!arst_n) $fell(adc_eoc_b) |=> adc_eoc_b
   ) else $error("adc_eoc_b stayed low for more than one cycle");

   // Accepted start is followed by the strobe 13 edges later
   a_soc_to_eoc: assert property (
      @(posedge clk40) disable iff (!arst_n) (adc_soc && sample) |-> ##13 !adc_eoc_b
   ) else $error("adc_eoc_b not low 13 edges after adc_soc");

   a_eoc_after_soc: assert property (
      @(posedge clk40) disable iff (!arst_n) $fell(adc_eoc_b) |-> $past(adc_soc && sample, 13)
   ) else $error("adc_eoc_b fell without an adc_soc 13 edges earlier");

   a_out_stable: assert property (
      @(posedge clk40) disable iff (!arst_n) adc_eoc_b |-> $stable(adc_out)
   ) else $error("adc_out changed while adc_eoc_b was high");

endmodule : acb_assert

bind mon_adc_sar acb_assert i_acb_assert (
   .clk40     (clk40),
   .arst_n    (arst_n),
   .adc_soc   (adc_soc),
   .sample    (sample),
   .adc_eoc_b (adc_eoc_b),
   .adc_out   (adc_out)
);

// File: acb_pkg.sv
/*
 * Analog chip bottom shared definitions: code widths, monitor channel map,
 * scaling constants, ring oscillator prescaler table and the ADC state type
 */
package acb_pkg;

   // ------------------------------------------------------------------------
   // Monitoring ADC
   // ------------------------------------------------------------------------

   localparam int unsigned ADC_BITS     = 12;
   localparam int unsigned ADC_MAX_CODE = (1 << ADC_BITS) - 1;
   localparam int unsigned ADC_PTR_BITS = $clog2(ADC_BITS);

   // SAR sequencer states
   typedef enum logic [1:0] {
      ADC_IDLE    = 2'd0,
      ADC_CONVERT = 2'd1,
      ADC_DONE    = 2'd2
   } adc_state_t;

   // ------------------------------------------------------------------------
   // Monitoring multiplexer
   // ------------------------------------------------------------------------

   // Select bus width, bit 0 has no input behind it
   localparam int unsigned MON_CHANNELS = 40;

   localparam int unsigned CAL_DAC_BITS = 12;

   // Channel numbers, counted from 1 like the mux inputs
   localparam int unsigned CH_CAL_MI_A  = 1;
   localparam int unsigned CH_CAL_HI_A  = 2;
   localparam int unsigned CH_BANDGAP   = 10;
   localparam int unsigned CH_IREF      = 11;
   localparam int unsigned CH_CAL_MI_B  = 12;
   localparam int unsigned CH_CAL_HI_B  = 13;
   localparam int unsigned CH_LDO_FIRST = 23;
   localparam int unsigned LDO_MONITORS = 12;

   // Cal DACs span 1.2 V, the ADC reference is 0.9 V
   localparam int unsigned CAL_SCALE_NUM = 4;
   localparam int unsigned CAL_SCALE_DEN = 3;

   localparam int unsigned BANDGAP_CODE = 2730;

   // Reference current code, base plus one step per trim LSB
   localparam int unsigned IREF_TRIM_BITS = 4;
   localparam int unsigned IREF_CODE_BASE = 1792;
   localparam int unsigned IREF_CODE_STEP = 32;

   // ------------------------------------------------------------------------
   // Ring oscillators
   // ------------------------------------------------------------------------

   localparam int unsigned RING_CELLS         = 8;
   localparam int unsigned RING_COUNT_BITS    = 16;
   localparam int unsigned RING_PRESCALE_BITS = 3;

   // CKND0, CKND4, INVD0, INVD4, NAND0, NAND4, NORD0, NORD4
   localparam int unsigned RING_DIV [RING_CELLS] = '{1, 2, 3, 4, 5, 6, 7, 8};

endpackage : acb_pkg

// File: analog_chip_bottom.sv
/*
 * Analog chip bottom, digital view: monitoring mux with its ADC and the
 * ring oscillator bank
 */
`timescale 1ns/1ps

module analog_chip_bottom import acb_pkg::*; (
   input  logic                       clk40,
   input  logic                       arst_n,

   // Monitoring mux and ADC
   input  logic                       mon_enable,
   input  logic [MON_CHANNELS-1:0]    mon_vin_sel,
   input  logic [CAL_DAC_BITS-1:0]    dac_cal_hi,
   input  logic [CAL_DAC_BITS-1:0]    dac_cal_mi,
   input  logic [IREF_TRIM_BITS-1:0]  iref_trim,
   input  logic [ADC_BITS-1:0]        mon_ldo [LDO_MONITORS],
   input  logic                       adc_soc,
   output logic                       adc_eoc_b,
   output logic [ADC_BITS-1:0]        adc_out,

   // Ring oscillators
   input  logic                       ring_osc_reset,
   input  logic                       ring_osc_start_stopn,
   input  logic [RING_CELLS-1:0]      ring_osc_en,
   output logic [RING_COUNT_BITS-1:0] ring_osc_count [RING_CELLS]
);

   monitoring i_monitoring (
      .clk40       (clk40),
      .arst_n      (arst_n),
      .mon_enable  (mon_enable),
      .mon_vin_sel (mon_vin_sel),
      .dac_cal_hi  (dac_cal_hi),
      .dac_cal_mi  (dac_cal_mi),
      .iref_trim   (iref_trim),
      .mon_ldo     (mon_ldo),
      .adc_soc     (adc_soc),
      .adc_eoc_b   (adc_eoc_b),
      .adc_out     (adc_out)
   );

   ring_osc_bank i_ring_osc_bank (
      .clk40                (clk40),
      .arst_n               (arst_n),
      .ring_osc_reset       (ring_osc_reset),
      .ring_osc_start_stopn (ring_osc_start_stopn),
      .ring_osc_en          (ring_osc_en),
      .ring_osc_count       (ring_osc_count)
   );

endmodule : analog_chip_bottom

// File: mon_adc_sar.sv
/*
 * Monitoring ADC: 12-bit successive-approximation sequencer started by
 * adc_soc, result published with a one-cycle active-low adc_eoc_b strobe
 */
`timescale 1ns/1ps

module mon_adc_sar import acb_pkg::*; (
   input  logic                clk40,
   input  logic                arst_n,
   input  logic                adc_soc,
   input  logic [ADC_BITS-1:0] mon_code,
   output logic                sample,
   output logic                adc_eoc_b,
   output logic [ADC_BITS-1:0] adc_out
);

   adc_state_t              state;
   logic [ADC_PTR_BITS-1:0] bit_ptr;
   logic [ADC_BITS-1:0]     trial;
   logic [ADC_BITS-1:0]     test_code;
   logic [ADC_BITS-1:0]     resolved;

   // Input track-and-hold is open only while idle
   assign sample = (state == ADC_IDLE);

   // Comparator: try the current bit, keep it if the DAC stays below the input
   always_comb begin
      test_code          = trial;
      test_code[bit_ptr] = 1'b1;
      resolved           = (test_code <= mon_code) ? test_code : trial;
   end

   // ------------------------------------------------------------------------
   // Sequencer
   // ------------------------------------------------------------------------

   // SOC edge E0, bits at E1..E12, strobe low from E12 and seen low at E13
   always_ff @(posedge clk40 or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ADC_IDLE;
         bit_ptr   <= '0;
         adc_eoc_b <= 1'b1;
         adc_out   <= '0;
      end else begin
         case (state)
            ADC_IDLE: begin
               adc_eoc_b <= 1'b1;
               if (adc_soc) begin
                  state   <= ADC_CONVERT;
                  bit_ptr <= ADC_PTR_BITS'(ADC_BITS - 1);
               end
            end
            ADC_CONVERT: begin
               if (bit_ptr == '0) begin
                  state     <= ADC_DONE;
                  adc_out   <= resolved;
                  adc_eoc_b <= 1'b0;
               end else begin
                  bit_ptr <= bit_ptr - 1'b1;
               end
            end
            ADC_DONE: begin
               state     <= ADC_IDLE;
               adc_eoc_b <= 1'b1;
            end
            default: begin
               state     <= ADC_IDLE;
               adc_eoc_b <= 1'b1;
            end
         endcase
      end
   end

   // Successive approximation register
   always_ff @(posedge clk40) begin
      if (state == ADC_IDLE) begin
         trial <= '0;
      end else if (state == ADC_CONVERT) begin
         trial <= resolved;
      end
   end

endmodule : mon_adc_sar

// File: mon_input_select.sv
/*
 * Monitoring input selector: forms the 12-bit code of every mux channel
 * and holds the lowest selected one while the ADC converts
 */
`timescale 1ns/1ps

module mon_input_select import acb_pkg::*; (
   input  logic                      clk40,
   input  logic                      arst_n,
   input  logic                      mon_enable,
   input  logic [MON_CHANNELS-1:0]   mon_vin_sel,
   input  logic [CAL_DAC_BITS-1:0]   dac_cal_hi,
   input  logic [CAL_DAC_BITS-1:0]   dac_cal_mi,
   input  logic [IREF_TRIM_BITS-1:0] iref_trim,
   input  logic [ADC_BITS-1:0]       mon_ldo [LDO_MONITORS],
   input  logic                      sample,
   output logic [ADC_BITS-1:0]       mon_code
);

   logic [ADC_BITS-1:0] cal_hi_code;
   logic [ADC_BITS-1:0] cal_mi_code;
   logic [ADC_BITS-1:0] iref_code;
   logic [ADC_BITS-1:0] ch_code [MON_CHANNELS];
   logic [ADC_BITS-1:0] sel_code;

   // Map a cal DAC code onto the ADC range, clipped at full scale
   function automatic logic [ADC_BITS-1:0] scale_cal(input logic [CAL_DAC_BITS-1:0] dac_code);
      int unsigned scaled;
      scaled = (32'(dac_code) * CAL_SCALE_NUM) / CAL_SCALE_DEN;
      if (scaled > ADC_MAX_CODE) begin
         return ADC_BITS'(ADC_MAX_CODE);
      end
      return ADC_BITS'(scaled);
   endfunction

   assign cal_hi_code = scale_cal(dac_cal_hi);
   assign cal_mi_code = scale_cal(dac_cal_mi);

   // Untrimmed current plus trim steps, 2272 at most
   assign iref_code = ADC_BITS'(IREF_CODE_BASE + 32'(iref_trim) * IREF_CODE_STEP);

   // ------------------------------------------------------------------------
   // Channel map
   // ------------------------------------------------------------------------

   always_comb begin
      // Sensor and spare channels read zero
      for (int ch = 0; ch < MON_CHANNELS; ch++) begin
         ch_code[ch] = '0;
      end

      ch_code[CH_CAL_MI_A] = cal_mi_code;
      ch_code[CH_CAL_HI_A] = cal_hi_code;
      ch_code[CH_CAL_MI_B] = cal_mi_code;
      ch_code[CH_CAL_HI_B] = cal_hi_code;
      ch_code[CH_BANDGAP]  = ADC_BITS'(BANDGAP_CODE);
      ch_code[CH_IREF]     = iref_code;

      // Shunt-LDO monitors, digital regulator first
      for (int k = 0; k < LDO_MONITORS; k++) begin
         ch_code[CH_LDO_FIRST + k] = mon_ldo[k];
      end
   end

   // ------------------------------------------------------------------------
   // Channel select
   // ------------------------------------------------------------------------

   // Scan downward so the lowest set bit is the last one to write
   always_comb begin
      sel_code = '0;
      for (int ch = MON_CHANNELS - 1; ch >= 1; ch--) begin
         if (mon_vin_sel[ch]) begin
            sel_code = ch_code[ch];
         end
      end
      if (!mon_enable) begin
         sel_code = '0;
      end
   end

   // Tracks the mux while the ADC idles, frozen during a conversion
   always_ff @(posedge clk40 or negedge arst_n) begin
      if (!arst_n) begin
         mon_code <= '0;
      end else if (sample) begin
         mon_code <= sel_code;
      end
   end

endmodule : mon_input_select

// File: monitoring.sv
/*
 * Monitoring block: channel selector feeding the SAR ADC, the code is
 * captured at start of conversion
 */
`timescale 1ns/1ps

module monitoring import acb_pkg::*; (
   input  logic                      clk40,
   input  logic                      arst_n,
   input  logic                      mon_enable,
   input  logic [MON_CHANNELS-1:0]   mon_vin_sel,
   input  logic [CAL_DAC_BITS-1:0]   dac_cal_hi,
   input  logic [CAL_DAC_BITS-1:0]   dac_cal_mi,
   input  logic [IREF_TRIM_BITS-1:0] iref_trim,
   input  logic [ADC_BITS-1:0]       mon_ldo [LDO_MONITORS],
   input  logic                      adc_soc,
   output logic                      adc_eoc_b,
   output logic [ADC_BITS-1:0]       adc_out
);

   logic                sample;
   logic [ADC_BITS-1:0] mon_code;

   mon_input_select i_mon_input_select (
      .clk40       (clk40),
      .arst_n      (arst_n),
      .mon_enable  (mon_enable),
      .mon_vin_sel (mon_vin_sel),
      .dac_cal_hi  (dac_cal_hi),
      .dac_cal_mi  (dac_cal_mi),
      .iref_trim   (iref_trim),
      .mon_ldo     (mon_ldo),
      .sample      (sample),
      .mon_code    (mon_code)
   );

   mon_adc_sar i_mon_adc_sar (
      .clk40     (clk40),
      .arst_n    (arst_n),
      .adc_soc   (adc_soc),
      .mon_code  (mon_code),
      .sample    (sample),
      .adc_eoc_b (adc_eoc_b),
      .adc_out   (adc_out)
   );

endmodule : monitoring

// File: project.f
acb_pkg.sv
mon_input_select.sv
mon_adc_sar.sv
monitoring.sv
ring_osc_bank.sv
analog_chip_bottom.sv
acb_assert.sv
tb_checker.sv
tb_analog_chip_bottom.sv

// File: ring_osc_bank.sv
/*
 * Ring oscillator bank: one gated, prescaled 16-bit counter per
 * standard-cell ring type
 */
`timescale 1ns/1ps

module ring_osc_bank import acb_pkg::*; (
   input  logic                       clk40,
   input  logic                       arst_n,
   input  logic                       ring_osc_reset,
   input  logic                       ring_osc_start_stopn,
   input  logic [RING_CELLS-1:0]      ring_osc_en,
   output logic [RING_COUNT_BITS-1:0] ring_osc_count [RING_CELLS]
);

   // ------------------------------------------------------------------------
   // One prescaler and counter per cell
   // ------------------------------------------------------------------------

   for (genvar g = 0; g < RING_CELLS; g++) begin : g_ring

      // Last prescaler state before the counter steps
      localparam logic [RING_PRESCALE_BITS-1:0] PRESC_LAST =
         RING_PRESCALE_BITS'(RING_DIV[g] - 1);

      logic [RING_PRESCALE_BITS-1:0] presc;
      logic [RING_COUNT_BITS-1:0]    count;
      logic                          running;

      // Gate shared by both stages
      assign running = ring_osc_start_stopn & ring_osc_en[g];

      always_ff @(posedge clk40 or negedge arst_n) begin
         if (!arst_n) begin
            presc <= '0;
            count <= '0;
         end else if (ring_osc_reset) begin
            presc <= '0;
            count <= '0;
         end else if (running) begin
            if (presc == PRESC_LAST) begin
               presc <= '0;
               // Free-running, wraps at full scale
               count <= count + 1'b1;
            end else begin
               presc <= presc + 1'b1;
            end
         end
      end

      assign ring_osc_count[g] = count;

   end : g_ring

endmodule : ring_osc_bank

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f \
   --top-module tb_analog_chip_bottom -o tb_sim || exit 1
sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1

// File: tb_analog_chip_bottom.sv
/*
 * Testbench for the analog chip bottom: clock, reset, stimulus table
 * applied in a loop, watchdog and the DUT with its checker
 */
`timescale 1ns/1ps

module tb_analog_chip_bottom import acb_pkg::*; ();

   localparam int K_RESET  = 0;
   localparam int K_ADC    = 1;
   localparam int K_DOUBLE = 2;
   localparam int K_RING   = 3;
   localparam int K_CLEAR  = 4;
   localparam int NUM_ROWS = 23;

   typedef struct {
      int                        kind;
      logic                      enable;
      logic [MON_CHANNELS-1:0]   sel;
      logic [CAL_DAC_BITS-1:0]   cal_hi;
      logic [CAL_DAC_BITS-1:0]   cal_mi;
      logic                      rand_cal;
      logic [IREF_TRIM_BITS-1:0] trim;
      logic                      rand_ldo;
      logic [RING_CELLS-1:0]     ring_en;
      int                        run_len;
   } row_t;

   logic                       clk40;
   logic                       arst_n;
   logic                       mon_enable;
   logic [MON_CHANNELS-1:0]    mon_vin_sel;
   logic [CAL_DAC_BITS-1:0]    dac_cal_hi;
   logic [CAL_DAC_BITS-1:0]    dac_cal_mi;
   logic [IREF_TRIM_BITS-1:0]  iref_trim;
   logic [ADC_BITS-1:0]        mon_ldo [LDO_MONITORS];
   logic                       adc_soc;
   logic                       adc_eoc_b;
   logic [ADC_BITS-1:0]        adc_out;
   logic                       ring_osc_reset;
   logic                       ring_osc_start_stopn;
   logic [RING_CELLS-1:0]      ring_osc_en;
   logic [RING_COUNT_BITS-1:0] ring_osc_count [RING_CELLS];
   logic                       test_done;
   int                         test_kind;
   int                         test_id;
   int                         err_count;
   int                         check_count;
   row_t                       table_rows [NUM_ROWS];

   initial clk40 = 1'b0;
   always #2 clk40 = ~clk40;

   analog_chip_bottom i_analog_chip_bottom (
      .clk40                (clk40),
      .arst_n               (arst_n),
      .mon_enable           (mon_enable),
      .mon_vin_sel          (mon_vin_sel),
      .dac_cal_hi           (dac_cal_hi),
      .dac_cal_mi           (dac_cal_mi),
      .iref_trim            (iref_trim),
      .mon_ldo              (mon_ldo),
      .adc_soc              (adc_soc),
      .adc_eoc_b            (adc_eoc_b),
      .adc_out              (adc_out),
      .ring_osc_reset       (ring_osc_reset),
      .ring_osc_start_stopn (ring_osc_start_stopn),
      .ring_osc_en          (ring_osc_en),
      .ring_osc_count       (ring_osc_count)
   );

   tb_checker i_tb_checker (
      .clk40                (clk40),
      .arst_n               (arst_n),
      .mon_enable           (mon_enable),
      .mon_vin_sel          (mon_vin_sel),
      .dac_cal_hi           (dac_cal_hi),
      .dac_cal_mi           (dac_cal_mi),
      .iref_trim            (iref_trim),
      .mon_ldo              (mon_ldo),
      .adc_soc              (adc_soc),
      .adc_eoc_b            (adc_eoc_b),
      .adc_out              (adc_out),
      .ring_osc_reset       (ring_osc_reset),
      .ring_osc_start_stopn (ring_osc_start_stopn),
      .ring_osc_en          (ring_osc_en),
      .ring_osc_count       (ring_osc_count),
      .test_done            (test_done),
      .test_kind            (test_kind),
      .test_id              (test_id),
      .err_count            (err_count),
      .check_count          (check_count)
   );

   // ------------------------------------------------------------------------
   // Stimulus table
   // ------------------------------------------------------------------------

   function automatic logic [MON_CHANNELS-1:0] chan(input int unsigned n);
      return MON_CHANNELS'(1) << n;
   endfunction

   task automatic set_row(input int r, input int kind, input logic en,
                          input logic [MON_CHANNELS-1:0] sel, input logic [11:0] hi,
                          input logic [11:0] mi, input logic rnd_cal, input logic [3:0] trim,
                          input logic rnd_ldo, input logic [7:0] ring_en, input int run_len);
      table_rows[r] = '{kind, en, sel, hi, mi, rnd_cal, trim, rnd_ldo, ring_en, run_len};
   endtask

   task automatic fill_table();
      set_row(0,  K_RESET,  1'b0, '0, 12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      // Calibration channels, last two saturate
      set_row(1,  K_ADC,    1'b1, chan(CH_CAL_MI_A), 12'h000, 12'h5a3, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(2,  K_ADC,    1'b1, chan(CH_CAL_HI_A), 12'h400, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(3,  K_ADC,    1'b1, chan(CH_CAL_MI_B), 12'h000, 12'hfff, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(4,  K_ADC,    1'b1, chan(CH_CAL_HI_B), 12'hc00, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(5,  K_ADC,    1'b1, chan(CH_CAL_HI_B), 12'h000, 12'h000, 1'b1, 4'd0, 1'b0, 8'h00, 0);
      set_row(6,  K_ADC,    1'b1, chan(CH_CAL_MI_A), 12'h000, 12'h000, 1'b1, 4'd0, 1'b0, 8'h00, 0);
      set_row(7,  K_ADC,    1'b1, chan(CH_BANDGAP),  12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(8,  K_ADC,    1'b1, chan(CH_IREF),     12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(9,  K_ADC,    1'b1, chan(CH_IREF),     12'h000, 12'h000, 1'b0, 4'd7, 1'b0, 8'h00, 0);
      set_row(10, K_ADC,    1'b1, chan(CH_IREF),     12'h000, 12'h000, 1'b0, 4'd15, 1'b0, 8'h00, 0);
      // LDO monitors with fresh random codes
      set_row(11, K_ADC,    1'b1, chan(23), 12'h000, 12'h000, 1'b0, 4'd0, 1'b1, 8'h00, 0);
      set_row(12, K_ADC,    1'b1, chan(28), 12'h000, 12'h000, 1'b0, 4'd0, 1'b1, 8'h00, 0);
      set_row(13, K_ADC,    1'b1, chan(34), 12'h000, 12'h000, 1'b0, 4'd0, 1'b1, 8'h00, 0);
      // Sensor channel, empty select, disabled mux
      set_row(14, K_ADC,    1'b1, chan(5),  12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(15, K_ADC,    1'b1, '0,       12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(16, K_ADC,    1'b0, chan(CH_BANDGAP), 12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(17, K_ADC,    1'b1, chan(CH_CAL_HI_A) | chan(CH_BANDGAP) | chan(23),
              12'h123, 12'h000, 1'b0, 4'd0, 1'b0, 8'h00, 0);
      set_row(18, K_DOUBLE, 1'b1, chan(CH_BANDGAP), 12'h000, 12'h000, 1'b0, 4'd3, 1'b0, 8'h00, 0);
      // Ring oscillator runs and clear
      set_row(19, K_RING,   1'b0, '0, 12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'hff, 24);
      set_row(20, K_RING,   1'b0, '0, 12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'h5a, 17);
      set_row(21, K_CLEAR,  1'b0, '0, 12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'hff, 0);
      set_row(22, K_RING,   1'b0, '0, 12'h000, 12'h000, 1'b0, 4'd0, 1'b0, 8'hc3, 30);
   endtask

   // ------------------------------------------------------------------------
   // Drivers, all changes 1 ns after the rising edge
   // ------------------------------------------------------------------------

   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk40);
         #1;
      end
   endtask

   task automatic pulse_soc();
      adc_soc = 1'b1;
      step(1);
      adc_soc = 1'b0;
   endtask

   task automatic wait_eoc();
      int waited;
      waited = 0;
      while (adc_eoc_b && waited < 20) begin
         step(1);
         waited++;
      end
   endtask

   task automatic run_row(input int r);
      row_t row;
      row = table_rows[r];
      if (row.rand_cal) begin
         row.cal_hi = 12'($urandom);
         row.cal_mi = 12'($urandom);
      end
      if (row.rand_ldo) begin
         for (int k = 0; k < LDO_MONITORS; k++) begin
            mon_ldo[k] = 12'($urandom);
         end
      end
      mon_enable  = row.enable;
      mon_vin_sel = row.sel;
      dac_cal_hi  = row.cal_hi;
      dac_cal_mi  = row.cal_mi;
      iref_trim   = row.trim;
      ring_osc_en = row.ring_en;
      case (row.kind)
         K_ADC: begin
            pulse_soc();
            wait_eoc();
            step(2);
         end
         K_DOUBLE: begin
            pulse_soc();
            step(4);
            // Second start and new input mid-conversion, both ignored
            mon_vin_sel = chan(CH_IREF);
            pulse_soc();
            wait_eoc();
            step(16);
         end
         K_RING: begin
            ring_osc_reset = 1'b1;
            step(1);
            ring_osc_reset       = 1'b0;
            ring_osc_start_stopn = 1'b1;
            step(row.run_len);
            ring_osc_start_stopn = 1'b0;
            step(4);
         end
         K_CLEAR: begin
            ring_osc_reset = 1'b1;
            step(1);
            ring_osc_reset = 1'b0;
            step(2);
         end
         default: step(1);
      endcase
      test_kind = row.kind;
      test_id   = r;
      test_done = 1'b1;
      step(1);
      test_done = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------------------

   initial begin
      void'($urandom(32'h6c59));
      arst_n               = 1'b0;
      mon_enable           = 1'b0;
      mon_vin_sel          = '0;
      dac_cal_hi           = '0;
      dac_cal_mi           = '0;
      iref_trim            = '0;
      adc_soc              = 1'b0;
      ring_osc_reset       = 1'b0;
      ring_osc_start_stopn = 1'b0;
      ring_osc_en          = '0;
      test_done            = 1'b0;
      test_kind            = K_RESET;
      test_id              = 0;
      for (int k = 0; k < LDO_MONITORS; k++) begin
         mon_ldo[k] = '0;
      end
      fill_table();
      repeat (16) @(posedge clk40);
      #1;
      arst_n = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      step(2);
      $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, check_count, err_count);
      if (err_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      repeat (NUM_ROWS * 40 + 200) @(posedge clk40);
      $display("watchdog expired, the run did not finish in time");
      $display("TB FAILED");
      $finish;
   end

endmodule : tb_analog_chip_bottom

// File: tb_checker.sv
/*
 * Testbench checker that follows the DUT pins, derives the expected ADC
 * results and ring counts, reports each test and keeps the totals
 */
`timescale 1ns/1ps

module tb_checker import acb_pkg::*; (
   input  logic                       clk40,
   input  logic                       arst_n,
   input  logic                       mon_enable,
   input  logic [MON_CHANNELS-1:0]    mon_vin_sel,
   input  logic [CAL_DAC_BITS-1:0]    dac_cal_hi,
   input  logic [CAL_DAC_BITS-1:0]    dac_cal_mi,
   input  logic [IREF_TRIM_BITS-1:0]  iref_trim,
   input  logic [ADC_BITS-1:0]        mon_ldo [LDO_MONITORS],
   input  logic                       adc_soc,
   input  logic                       adc_eoc_b,
   input  logic [ADC_BITS-1:0]        adc_out,
   input  logic                       ring_osc_reset,
   input  logic                       ring_osc_start_stopn,
   input  logic [RING_CELLS-1:0]      ring_osc_en,
   input  logic [RING_COUNT_BITS-1:0] ring_osc_count [RING_CELLS],
   input  logic                       test_done,
   input  int                         test_kind,
   input  int                         test_id,
   output int                         err_count,
   output int                         check_count
);

   localparam int K_RESET  = 0;
   localparam int K_ADC    = 1;
   localparam int K_DOUBLE = 2;
   localparam int K_RING   = 3;
   localparam int K_CLEAR  = 4;

   int unsigned         run_cycles [RING_CELLS];
   logic                busy = 1'b0;
   int                  conv_edges = 0;
   logic [ADC_BITS-1:0] exp_code = '0;
   int                  strobes = 0;
   int                  test_errors = 0;
   int                  errors = 0;
   int                  checks = 0;

   assign err_count   = errors;
   assign check_count = checks;

   function automatic logic [ADC_BITS-1:0] cal_expect(input logic [CAL_DAC_BITS-1:0] dac);
      int unsigned v;
      v = 32'(dac) * CAL_SCALE_NUM / CAL_SCALE_DEN;
      if (v > 4095) begin
         v = 4095;
      end
      return ADC_BITS'(v);
   endfunction

   // Lowest set select bit from 1 upward
   function automatic logic [ADC_BITS-1:0] channel_expect();
      int unsigned ch;
      ch = 0;
      for (int unsigned i = 1; i < MON_CHANNELS; i++) begin
         if (mon_vin_sel[i] && ch == 0) begin
            ch = i;
         end
      end
      if (!mon_enable || ch == 0) return '0;
      if (ch == CH_CAL_MI_A || ch == CH_CAL_MI_B) return cal_expect(dac_cal_mi);
      if (ch == CH_CAL_HI_A || ch == CH_CAL_HI_B) return cal_expect(dac_cal_hi);
      if (ch == CH_BANDGAP) return ADC_BITS'(BANDGAP_CODE);
      if (ch == CH_IREF) return ADC_BITS'(IREF_CODE_BASE + 32'(iref_trim) * IREF_CODE_STEP);
      if (ch >= CH_LDO_FIRST && ch < CH_LDO_FIRST + LDO_MONITORS) begin
         return mon_ldo[ch - CH_LDO_FIRST];
      end
      return '0;
   endfunction

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         test_errors++;
         $display("error %s: expected 0x%h, actual 0x%h", name, expected, actual);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      test_errors++;
      $display("%s", msg);
   endtask

   task automatic check_rings(input logic zero);
      logic [15:0] expected;
      for (int i = 0; i < RING_CELLS; i++) begin
         expected = zero ? 16'h0 : 16'(run_cycles[i] / RING_DIV[i]);
         check_value($sformatf("ring_osc_count[%0d]", i), expected, ring_osc_count[i]);
      end
   endtask

   task automatic report_test();
      case (test_kind)
         K_RESET: begin
            check_value("adc_eoc_b", 16'h1, 16'(adc_eoc_b));
            check_value("adc_out", 16'h0, 16'(adc_out));
            check_rings(1'b1);
         end
         K_ADC, K_DOUBLE: begin
            checks++;
            if (strobes != 1) begin
               report_failure(
                  $sformatf("expected one end-of-conversion strobe, saw %0d", strobes));
            end
         end
         K_RING, K_CLEAR: begin
            check_rings(1'b0);
         end
         default: begin
            report_failure($sformatf("unknown test kind %0d", test_kind));
         end
      endcase
      $display("test %0d kind %0d: %s", test_id, test_kind, (test_errors == 0) ? "ok" : "mismatch");
      strobes     = 0;
      test_errors = 0;
   endtask

   // ------------------------------------------------------------------------
   // Reference behavior sampled at the rising edge
   // ------------------------------------------------------------------------

   always @(posedge clk40 or negedge arst_n) begin
      if (!arst_n) begin
         busy       = 1'b0;
         conv_edges = 0;
         for (int i = 0; i < RING_CELLS; i++) begin
            run_cycles[i] = 0;
         end
      end else begin
         for (int i = 0; i < RING_CELLS; i++) begin
            if (ring_osc_reset) begin
               run_cycles[i] = 0;
            end else if (ring_osc_start_stopn && ring_osc_en[i]) begin
               run_cycles[i]++;
            end
         end
         if (busy) begin
            conv_edges++;
            if (conv_edges == 13) begin
               busy = 1'b0;
               if (adc_eoc_b) begin
                  report_failure("no end-of-conversion strobe 13 cycles after the start");
               end else begin
                  strobes++;
                  check_value("adc_out", 16'(exp_code), 16'(adc_out));
               end
            end else if (!adc_eoc_b) begin
               report_failure("end-of-conversion strobe came before the conversion ended");
            end
         end else begin
            if (!adc_eoc_b) begin
               report_failure("end-of-conversion strobe without a conversion");
            end
            if (adc_soc) begin
               busy       = 1'b1;
               conv_edges = 0;
               exp_code   = channel_expect();
            end
         end
         if (test_done) begin
            report_test();
         end
      end
   end

endmodule : tb_checker
